// File: design/orbPkg.sv
package orbPkg;

	// Input byte and the 12-bit word stored in the frame.
	typedef logic [7:0] orbByte_t;
	typedef logic [11:0] orbWord_t;

	// Frame memory address, packet number in the upper six bits.
	typedef logic [10:0] orbAddr_t;
	typedef logic [5:0] orbPacket_t;

	typedef logic [3:0] orbSlotIdx_t;  // Position in the channel slot order.
	typedef logic [4:0] orbWordCnt_t;  // Strobe count inside one packet.

	typedef enum logic [1:0] {
		IDLE,
		SETTLE,
		HOLD
	} orbChanState_t;

	localparam int frameDepth = 2048;
	localparam int packetWords = 32;
	localparam int strobesPerPacket = 17;

	// Settle counter values, counted from the first cycle in SETTLE.
	localparam int settleCycles = 28;
	localparam int settleEnd = 32;

	// Slot order within a packet.
	// Index 0..7 walks 0,4,..,28 and index 8..15 walks 2,6,..,30.
	// Parity picks the even or the odd half of the packet.
	function automatic logic [4:0] orbSlot(
		input logic parity,
		input orbSlotIdx_t index
	);
		logic [4:0] slot;
		if (index < 4'd8) begin
			slot = {index[2:0], 2'b00};
		end else begin
			slot = {index[2:0], 2'b10};
		end
		slot[0] = parity;
		return slot;
	endfunction

endpackage

// File: design/orbChannel.sv
`timescale 1ns/1ps

module orbChannel #(
	parameter bit parity = 1'b0,   // 0 for even slots, 1 for odd.
	parameter int dataWords = 16   // Data strobes per packet.
) (
	input logic clk,
	input logic rst,
	input orbPkg::orbByte_t data,
	input logic strobe,
	input logic resync,
	output orbPkg::orbWord_t wrWord,
	output orbPkg::orbAddr_t wrAddr,
	output logic wrEn
);

	logic [1:0] strobeSync;
	logic strobeHi;

	orbPkg::orbChanState_t state;
	orbPkg::orbWordCnt_t wordCnt;
	orbPkg::orbPacket_t packetCnt;
	orbPkg::orbSlotIdx_t slotIdx;

	logic [5:0] settleCnt;
	logic [5:0] settleNext;

	logic strobeTake;
	logic dataStrobe;
	logic lastStrobe;
	logic slotWrap;

	// Two flop synchronizer on the strobe level.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			strobeSync <= 2'b00;
		end else begin
			strobeSync <= {strobeSync[0], strobe};
		end
	end

	assign strobeHi = strobeSync[1];

	// A strobe only counts once per high phase, when the FSM is idle.
	assign strobeTake = (state == orbPkg::IDLE) && strobeHi;

	assign dataStrobe = wordCnt < orbPkg::orbWordCnt_t'(dataWords);
	assign lastStrobe = wordCnt == orbPkg::orbWordCnt_t'(orbPkg::strobesPerPacket - 1);
	assign slotWrap = slotIdx == orbPkg::orbSlotIdx_t'(dataWords - 1);

	assign settleNext = settleCnt + 6'd1;

	// Word, packet and slot counters.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wordCnt <= '0;
			packetCnt <= '0;
			slotIdx <= '0;
		end else if (resync) begin
			wordCnt <= '0;  // Mode change restarts the frame.
			packetCnt <= '0;
			slotIdx <= '0;
		end else if (strobeTake) begin
			if (lastStrobe) begin
				wordCnt <= '0;
				packetCnt <= packetCnt + 1'b1;  // Wraps after 64 packets.
			end else begin
				wordCnt <= wordCnt + 1'b1;
			end
			if (dataStrobe) begin
				if (slotWrap) begin
					slotIdx <= '0;
				end else begin
					slotIdx <= slotIdx + 1'b1;
				end
			end
		end
	end

	// Word and address are captured on the strobe and held through SETTLE.
	always_ff @(posedge clk) begin
		if (strobeTake && dataStrobe) begin
			wrWord <= orbPkg::orbWord_t'({1'b0, data, 3'b000});
			wrAddr <= orbPkg::orbAddr_t'(packetCnt) * orbPkg::orbAddr_t'(orbPkg::packetWords)
				+ orbPkg::orbAddr_t'(orbPkg::orbSlot(parity, slotIdx));
		end
	end

	// Channel FSM with the delayed write enable.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= orbPkg::IDLE;
			settleCnt <= '0;
			wrEn <= 1'b0;
		end else begin
			case (state)
				orbPkg::IDLE: begin
					if (strobeHi) begin
						settleCnt <= '0;
						if (dataStrobe) begin
							state <= orbPkg::SETTLE;
						end else begin
							state <= orbPkg::HOLD;  // Padding strobe, nothing to write.
						end
					end
				end
				orbPkg::SETTLE: begin
					settleCnt <= settleNext;
					if (settleNext == 6'(orbPkg::settleCycles)) begin
						wrEn <= 1'b1;
					end
					if (settleNext == 6'(orbPkg::settleEnd)) begin
						state <= orbPkg::HOLD;
					end
				end
				orbPkg::HOLD: begin
					// Wait for the strobe to go low before the next one.
					if (!strobeHi) begin
						wrEn <= 1'b0;
						state <= orbPkg::IDLE;
					end
				end
				default: begin
					state <= orbPkg::IDLE;
				end
			endcase
		end
	end

	// The write enable may only come up while the settle time runs.
	wrEnRiseInSettle: assert property (
		@(posedge clk) disable iff (!rst)
		$rose(wrEn) |-> state == orbPkg::SETTLE
	) else $error("wrEn rose outside SETTLE");

endmodule

// File: design/orbFrameStore.sv
`timescale 1ns/1ps

module orbFrameStore (
	input logic clk,
	input logic rst,
	input orbPkg::orbWord_t wrWordA,
	input orbPkg::orbAddr_t wrAddrA,
	input logic wrEnA,
	input orbPkg::orbWord_t wrWordB,
	input orbPkg::orbAddr_t wrAddrB,
	input logic wrEnB,
	input logic modeSw,
	input orbPkg::orbAddr_t rdAddr,
	output orbPkg::orbWord_t rdData,
	output logic resync,
	output logic modeMark
);

	orbPkg::orbWord_t mem [orbPkg::frameDepth];

	logic wrEnQA;
	logic wrEnQB;
	logic riseA;
	logic riseB;

	logic pendValid;
	orbPkg::orbWord_t pendWord;
	orbPkg::orbAddr_t pendAddr;
	logic loadPend;

	logic memWe;
	orbPkg::orbAddr_t memAddr;
	orbPkg::orbWord_t memData;

	logic [1:0] swSync;
	logic swQ;
	logic swChange;

	// Write enables are levels; only the rising edge writes.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wrEnQA <= 1'b0;
			wrEnQB <= 1'b0;
		end else begin
			wrEnQA <= wrEnA;
			wrEnQB <= wrEnB;
		end
	end

	assign riseA = wrEnA && !wrEnQA;
	assign riseB = wrEnB && !wrEnQB;
	assign loadPend = riseA && riseB;  // B waits one cycle behind A.

	// Single write port, A first, then a parked B word.
	always_comb begin
		memWe = 1'b1;
		memAddr = wrAddrA;
		memData = wrWordA;
		if (riseA) begin
			memAddr = wrAddrA;
			memData = wrWordA;
		end else if (pendValid) begin
			memAddr = pendAddr;
			memData = pendWord;
		end else if (riseB) begin
			memAddr = wrAddrB;
			memData = wrWordB;
		end else begin
			memWe = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pendValid <= 1'b0;
		end else if (loadPend) begin
			pendValid <= 1'b1;
		end else if (!riseA) begin
			pendValid <= 1'b0;  // Drained this cycle.
		end
	end

	always_ff @(posedge clk) begin
		if (loadPend) begin
			pendWord <= wrWordB;
			pendAddr <= wrAddrB;
		end
	end

	// Frame memory with a registered read port.
	always_ff @(posedge clk) begin
		if (memWe) begin
			mem[memAddr] <= memData;
		end
		rdData <= mem[rdAddr];
	end

	// Mode switch sync and change detect.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			swSync <= 2'b00;
			swQ <= 1'b0;
			modeMark <= 1'b0;
		end else begin
			swSync <= {swSync[0], modeSw};
			swQ <= swSync[1];
			modeMark <= swChange;
		end
	end

	assign swChange = swSync[1] ^ swQ;
	assign resync = modeMark;  // Same pulse restarts both channels.

	// Channels are spaced far enough apart that one parked word suffices.
	pendNoOverrun: assert property (
		@(posedge clk) disable iff (!rst)
		loadPend |-> !pendValid
	) else $error("pending buffer loaded while full");

	// A owns the even slots and B the odd ones.
	chanParity: assert property (
		@(posedge clk) disable iff (!rst)
		(riseA && riseB) |-> wrAddrA[0] != wrAddrB[0]
	) else $error("channel write addresses share parity");

endmodule

// File: design/orbPacker.sv
`timescale 1ns/1ps

module orbPacker (
	input logic clk,
	input logic rst,
	input orbPkg::orbByte_t dataA,
	input orbPkg::orbByte_t dataB,
	input logic strobeA,
	input logic strobeB,
	input logic modeSw,
	input orbPkg::orbAddr_t rdAddr,
	output orbPkg::orbWord_t rdData,
	output logic modeMark
);

	orbPkg::orbWord_t wrWordA;
	orbPkg::orbWord_t wrWordB;
	orbPkg::orbAddr_t wrAddrA;
	orbPkg::orbAddr_t wrAddrB;
	logic wrEnA;
	logic wrEnB;
	logic resync;

	// Channel A fills even slots with 16 words per packet.
	orbChannel #(
		.parity(1'b0),
		.dataWords(16)
	) uChanA (
		.clk(clk),
		.rst(rst),
		.data(dataA),
		.strobe(strobeA),
		.resync(resync),
		.wrWord(wrWordA),
		.wrAddr(wrAddrA),
		.wrEn(wrEnA)
	);

	// Channel B fills odd slots, slot 31 is never used.
	orbChannel #(
		.parity(1'b1),
		.dataWords(15)
	) uChanB (
		.clk(clk),
		.rst(rst),
		.data(dataB),
		.strobe(strobeB),
		.resync(resync),
		.wrWord(wrWordB),
		.wrAddr(wrAddrB),
		.wrEn(wrEnB)
	);

	orbFrameStore uStore (
		.clk(clk),
		.rst(rst),
		.wrWordA(wrWordA),
		.wrAddrA(wrAddrA),
		.wrEnA(wrEnA),
		.wrWordB(wrWordB),
		.wrAddrB(wrAddrB),
		.wrEnB(wrEnB),
		.modeSw(modeSw),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.resync(resync),
		.modeMark(modeMark)
	);

endmodule

// File: bench/orbClockGen.sv
`timescale 1ns/1ps

module orbClockGen #(
	parameter int periodNs = 4,
	parameter int resetCycles = 5
) (
	input logic rstReq,  // Requests another reset later in the run.
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2.0) clk = ~clk;
	end

	// Reset is low for resetCycles clocks at start and after each request.
	initial begin
		rst = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b1;
		forever begin
			@(posedge clk);
			if (rstReq) begin
				rst <= 1'b0;
				repeat (resetCycles) @(posedge clk);
				rst <= 1'b1;
			end
		end
	end

endmodule

// File: bench/orbRef.svh
`ifndef ORB_REF_SVH
`define ORB_REF_SVH

// Expected frame contents, indexed by memory address.
orbPkg::orbWord_t model [orbPkg::frameDepth];
bit modelValid [orbPkg::frameDepth];

int pktCnt [2];  // Packet of each channel, A at 0 and B at 1.
int idxCnt [2];  // Strobe count inside the current packet.

localparam int dataWordsA = 16;
localparam int dataWordsB = 15;

function automatic orbPkg::orbAddr_t refAddr(input bit chan, input int packet, input int index);
	orbPkg::orbAddr_t addr;
	addr = orbPkg::orbAddr_t'(packet * orbPkg::packetWords);
	addr = addr + orbPkg::orbAddr_t'(orbPkg::orbSlot(chan, orbPkg::orbSlotIdx_t'(index)));
	return addr;
endfunction

// Zero bit, the byte, then three zero bits.
function automatic orbPkg::orbWord_t refWord(input orbPkg::orbByte_t b);
	return {1'b0, b, 3'b000};
endfunction

function automatic void recordStrobe(input bit chan, input orbPkg::orbByte_t b);
	int words;
	orbPkg::orbAddr_t addr;
	words = chan ? dataWordsB : dataWordsA;
	if (idxCnt[chan] < words) begin
		addr = refAddr(chan, pktCnt[chan], idxCnt[chan]);
		model[addr] = refWord(b);
		modelValid[addr] = 1'b1;
	end
	idxCnt[chan]++;
	if (idxCnt[chan] == orbPkg::strobesPerPacket) begin
		idxCnt[chan] = 0;
		pktCnt[chan] = (pktCnt[chan] + 1) % (orbPkg::frameDepth / orbPkg::packetWords);
	end
endfunction

function automatic void restartCounters();
	pktCnt[0] = 0;
	pktCnt[1] = 0;
	idxCnt[0] = 0;
	idxCnt[1] = 0;
endfunction

task automatic checkWord(input string testName, input orbPkg::orbWord_t expected,
	input orbPkg::orbWord_t actual);
	if (actual !== expected) begin
		failRun($sformatf("FAIL %s expected %03h actual %03h", testName, expected, actual));
	end
endtask

task automatic checkMark(input string testName, input logic expected, input logic actual);
	if (actual !== expected) begin
		failRun($sformatf("FAIL %s expected %b actual %b", testName, expected, actual));
	end
endtask

`endif

// File: bench/orbPackerTb.sv
`timescale 1ns/1ps

module orbPackerTb;

	localparam int strobeHigh = 40;
	localparam int strobeLow = 6;
	localparam int strobeCycles = strobeHigh + strobeLow;
	localparam int wrapPackets = orbPkg::frameDepth / orbPkg::packetWords;
	localparam int sweepCycles = orbPkg::frameDepth + 1;

	// Phases 1 to 3 take five packets and the wrap phase 62 more, followed by 8 and 2 strobes.
	localparam int totalStrobes = (5 + wrapPackets - 2) * orbPkg::strobesPerPacket + 8 + 2;
	localparam int cycleLimit = (totalStrobes * strobeCycles + 6 * sweepCycles + 400) * 3 / 2;

	logic clk;
	logic rst;
	logic rstReq;
	orbPkg::orbByte_t dataA;
	orbPkg::orbByte_t dataB;
	logic strobeA;
	logic strobeB;
	logic modeSw;
	orbPkg::orbAddr_t rdAddr;
	orbPkg::orbWord_t rdData;
	logic modeMark;
	int cycleCount = 0;

	orbClockGen #(
		.periodNs(4),
		.resetCycles(5)
	) uClk (
		.rstReq(rstReq),
		.clk(clk),
		.rst(rst)
	);

	orbPacker u_dut (
		.clk(clk),
		.rst(rst),
		.dataA(dataA),
		.dataB(dataB),
		.strobeA(strobeA),
		.strobeB(strobeB),
		.modeSw(modeSw),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.modeMark(modeMark)
	);

	task automatic failRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "orbRef.svh"

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == cycleLimit) begin
			failRun($sformatf("Timeout, the run did not finish within %0d cycles.", cycleLimit));
		end
	end

	function automatic orbPkg::orbByte_t randomByte();
		return orbPkg::orbByte_t'($urandom);
	endfunction

	// One strobe period of 40 cycles high and 6 low.
	task automatic pulseStrobes(input bit useA, input bit useB,
		input orbPkg::orbByte_t byteA, input orbPkg::orbByte_t byteB);
		@(posedge clk);
		if (useA) begin
			dataA <= byteA;
			strobeA <= 1'b1;
			recordStrobe(1'b0, byteA);
		end
		if (useB) begin
			dataB <= byteB;
			strobeB <= 1'b1;
			recordStrobe(1'b1, byteB);
		end
		repeat (strobeHigh) @(posedge clk);
		strobeA <= 1'b0;
		strobeB <= 1'b0;
		repeat (strobeLow - 1) @(posedge clk);
	endtask

	// Pipelined sweep where the word read back lags rdAddr by one cycle.
	task automatic readbackSweep(input string testName);
		for (int i = 0; i <= orbPkg::frameDepth; i++) begin
			@(posedge clk);
			if (i < orbPkg::frameDepth) begin
				rdAddr <= orbPkg::orbAddr_t'(i);
			end
			@(negedge clk);
			if (i > 0 && modelValid[i - 1]) begin
				checkWord($sformatf("%s addr %0d", testName, i - 1), model[i - 1], rdData);
			end
		end
	endtask

	task automatic readCheck(input string testName, input orbPkg::orbAddr_t addr);
		@(posedge clk);
		rdAddr <= addr;
		@(posedge clk);
		@(negedge clk);
		checkWord($sformatf("%s addr %0d", testName, addr), model[addr], rdData);
	endtask

	// modeMark must show up on the third cycle after the toggle and nowhere else.
	task automatic toggleMode();
		@(posedge clk);
		modeSw <= ~modeSw;
		for (int c = 1; c <= 8; c++) begin
			@(posedge clk);
			@(negedge clk);
			checkMark($sformatf("modeSw cycle %0d", c), c == 3, modeMark);
		end
		restartCounters();
	endtask

	initial begin
		void'($urandom(32'ha3c6_84c3));
		dataA = '0;
		dataB = '0;
		strobeA = 1'b0;
		strobeB = 1'b0;
		modeSw = 1'b0;
		rdAddr = '0;
		rstReq = 1'b0;
		restartCounters();
		@(posedge rst);
		@(posedge clk);

		repeat (2 * orbPkg::strobesPerPacket) pulseStrobes(1'b1, 1'b0, randomByte(), 8'h00);
		readbackSweep("chanA");

		repeat (2 * orbPkg::strobesPerPacket) pulseStrobes(1'b0, 1'b1, 8'h00, randomByte());
		readbackSweep("chanB");

		// Same input edge on both channels sends B through the pending path.
		repeat (orbPkg::strobesPerPacket) pulseStrobes(1'b1, 1'b1, randomByte(), randomByte());
		readbackSweep("collision");

		// Channel A stands at packet 3 and runs past packet 63 into packet 1.
		repeat ((wrapPackets - 2) * orbPkg::strobesPerPacket) begin
			pulseStrobes(1'b1, 1'b0, randomByte(), 8'h00);
		end
		readbackSweep("wrap");

		repeat (5) pulseStrobes(1'b1, 1'b1, randomByte(), randomByte());
		toggleMode();
		repeat (3) pulseStrobes(1'b1, 1'b1, randomByte(), randomByte());
		readbackSweep("modeSw");

		// Second reset with the switch back at zero expects no mark.
		@(posedge clk);
		modeSw <= 1'b0;
		rstReq <= 1'b1;
		@(posedge clk);
		rstReq <= 1'b0;
		@(posedge rst);
		restartCounters();
		for (int c = 0; c < 10; c++) begin
			@(negedge clk);
			checkMark("reset", 1'b0, modeMark);
		end
		pulseStrobes(1'b1, 1'b0, 8'h5a, 8'h00);
		pulseStrobes(1'b0, 1'b1, 8'h00, 8'hc3);
		readCheck("reset preload", orbPkg::orbAddr_t'(0));
		readCheck("reset preload", orbPkg::orbAddr_t'(1));

		// Busy data lines with the strobes low must not reach the frame.
		for (int c = 0; c < 200; c++) begin
			@(posedge clk);
			dataA <= randomByte();
			dataB <= randomByte();
		end
		readbackSweep("reset idle");

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: files.f
+incdir+bench
design/orbPkg.sv
design/orbChannel.sv
design/orbFrameStore.sv
design/orbPacker.sv
bench/orbClockGen.sv
bench/orbPackerTb.sv

// File: Bender.yml
package:
  name: orb_packer

sources:
  - design/orbPkg.sv
  - design/orbChannel.sv
  - design/orbFrameStore.sv
  - design/orbPacker.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/orbClockGen.sv
      - bench/orbPackerTb.sv
